/* egr_tx_pkg.sv */
// ------------------------------------------------
// Egress transmit package
// Shared widths and encodings for the TQU pull
// scheduler, the port controllers and the counters
// ------------------------------------------------

package egr_tx_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------

    // TQU word and EPL word, eight bytes
    parameter int WORD_W = 64;

    // Length field of a control word, 1 to 15 data words
    parameter int LEN_W = 4;

    // Each forwarded and dropped packet counter
    parameter int CNT_W = 16;

    // ------------------------------------------------
    // Encodings
    // ------------------------------------------------

    // Control word opcode in bits 1..0
    // Length sits in bits 5..2, upper bits are ignored
    typedef enum logic [1:0] {
        CW_FORWARD = 2'd0,
        CW_DROP    = 2'd1
    } cw_op_e;

    // Port controller FSM
    typedef enum logic [1:0] {
        PS_IDLE = 2'd0,
        PS_SEND = 2'd1,
        PS_DROP = 2'd2
    } port_state_e;

endpackage : egr_tx_pkg

/* dtq_pull_sched.sv */
// ------------------------------------------------
// TQU pull scheduler
// Round-robin pulls over the per-port queues, one
// word per pull, and steers each returned word to
// the port controller it was pulled for
// ------------------------------------------------

`timescale 1ns/1ps

module dtq_pull_sched #(
    parameter int NUM_PORTS = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [NUM_PORTS-1:0]          dtq_ready,
    input  logic                          dtq_valid,
    input  logic [egr_tx_pkg::WORD_W-1:0] dtq_word,
    input  logic [NUM_PORTS-1:0]          lane_space,
    output logic [NUM_PORTS-1:0]          dtq_pull,
    output logic [NUM_PORTS-1:0]          lane_valid,
    output logic [egr_tx_pkg::WORD_W-1:0] lane_word
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    // Last granted port
    logic [IDX_W-1:0]     rr_ptr;
    // Port whose word is due back from the TQU this cycle
    logic [NUM_PORTS-1:0] inflight;
    logic [NUM_PORTS-1:0] eligible;
    logic [NUM_PORTS-1:0] grant;
    logic [IDX_W-1:0]     grant_idx;
    logic                 grant_any;

    // ------------------------------------------------
    // Port selection
    // ------------------------------------------------

    // A port with a word anywhere between pull and buffer is skipped
    // so its one-word buffer cannot overflow
    assign eligible = dtq_ready & lane_space & ~dtq_pull & ~inflight & ~lane_valid;

    always_comb begin
        int cand;
        grant     = '0;
        grant_idx = rr_ptr;
        grant_any = 1'b0;
        cand      = 0;
        // Search starts one past the last grant and wraps back to it
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!grant_any && eligible[cand]) begin
                grant[cand] = 1'b1;
                grant_idx   = IDX_W'(cand);
                grant_any   = 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // Pull and return pipeline
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr     <= '0;
            dtq_pull   <= '0;
            inflight   <= '0;
            lane_valid <= '0;
        end else begin
            // Registered one-hot pull pulse
            dtq_pull <= grant;
            // TQU answers one cycle after the pull
            inflight <= dtq_pull;
            // Word goes to the lane of the port that was pulled
            lane_valid <= inflight & {NUM_PORTS{dtq_valid}};
            if (grant_any) begin
                rr_ptr <= grant_idx;
            end
        end
    end

    // Lane word shared by all port controllers
    always_ff @(posedge clk) begin
        if (dtq_valid) begin
            lane_word <= dtq_word;
        end
    end

endmodule : dtq_pull_sched

/* tx_port_ctrl.sv */
// ------------------------------------------------
// Transmit port controller
// Decodes a control word, then forwards or drops the
// data words that follow toward one EPL port, with
// byte parity and start and end of packet marks
// ------------------------------------------------

`timescale 1ns/1ps

module tx_port_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lane_valid,
    input  logic [egr_tx_pkg::WORD_W-1:0]   lane_word,
    input  logic                            epl_ready,
    output logic                            lane_space,
    output logic                            tx_valid,
    output logic [egr_tx_pkg::WORD_W-1:0]   tx_data,
    output logic [egr_tx_pkg::WORD_W/8-1:0] tx_par,
    output logic                            tx_sop,
    output logic                            tx_eop,
    output logic                            pkt_fwd,
    output logic                            pkt_drop
);

    localparam int NUM_BYTES = egr_tx_pkg::WORD_W / 8;

    // One-word buffer fed by the scheduler lane
    logic                          buf_valid;
    logic [egr_tx_pkg::WORD_W-1:0] buf_word;
    logic                          buf_pop;

    egr_tx_pkg::port_state_e       state;
    logic [egr_tx_pkg::LEN_W-1:0]  words_left;
    logic                          first_word;
    logic                          last_word;

    // Control word fields, only meaningful in PS_IDLE
    egr_tx_pkg::cw_op_e            cw_op;
    logic [egr_tx_pkg::LEN_W-1:0]  cw_len;

    assign cw_op      = egr_tx_pkg::cw_op_e'(buf_word[1:0]);
    assign cw_len     = buf_word[2 +: egr_tx_pkg::LEN_W];
    assign last_word  = (words_left == 'd1);
    assign lane_space = ~buf_valid;

    // ------------------------------------------------
    // Buffer drain and EPL side
    // ------------------------------------------------

    always_comb begin
        buf_pop  = 1'b0;
        tx_valid = 1'b0;
        pkt_fwd  = 1'b0;
        pkt_drop = 1'b0;
        case (state)
            // Control word is absorbed as soon as it lands
            egr_tx_pkg::PS_IDLE: buf_pop = buf_valid;
            egr_tx_pkg::PS_SEND: begin
                tx_valid = buf_valid;
                buf_pop  = buf_valid & epl_ready;
                pkt_fwd  = buf_valid & epl_ready & last_word;
            end
            // Discard one data word per cycle
            egr_tx_pkg::PS_DROP: begin
                buf_pop  = buf_valid;
                pkt_drop = buf_valid & last_word;
            end
            default: buf_pop = 1'b0;
        endcase
    end

    assign tx_data = buf_word;
    assign tx_sop  = tx_valid & first_word;
    assign tx_eop  = tx_valid & last_word;

    // Even parity per byte stands in for ECC
    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            tx_par[b] = ^buf_word[8*b +: 8];
        end
    end

    // ------------------------------------------------
    // FSM and word countdown
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= egr_tx_pkg::PS_IDLE;
            buf_valid  <= 1'b0;
            words_left <= '0;
            first_word <= 1'b0;
        end else begin
            // Scheduler never writes a full buffer
            if (lane_valid) begin
                buf_valid <= 1'b1;
            end else if (buf_pop) begin
                buf_valid <= 1'b0;
            end
            case (state)
                egr_tx_pkg::PS_IDLE: begin
                    // Zero length control word carries no packet
                    if (buf_valid && cw_len != '0) begin
                        words_left <= cw_len;
                        first_word <= 1'b1;
                        // Any opcode other than DROP forwards
                        state <= (cw_op == egr_tx_pkg::CW_DROP) ? egr_tx_pkg::PS_DROP
                                                                : egr_tx_pkg::PS_SEND;
                    end
                end
                egr_tx_pkg::PS_SEND, egr_tx_pkg::PS_DROP: begin
                    if (buf_pop) begin
                        first_word <= 1'b0;
                        words_left <= words_left - 1'b1;
                        if (last_word) begin
                            state <= egr_tx_pkg::PS_IDLE;
                        end
                    end
                end
                default: state <= egr_tx_pkg::PS_IDLE;
            endcase
        end
    end

    // Buffer payload
    always_ff @(posedge clk) begin
        if (lane_valid) begin
            buf_word <= lane_word;
        end
    end

endmodule : tx_port_ctrl

/* tx_pkt_counter.sv */
// ------------------------------------------------
// Per-port packet counters
// Saturating forwarded and dropped counts for each
// port, read back by port index
// ------------------------------------------------

`timescale 1ns/1ps

module tx_pkt_counter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_PORTS-1:0]         pkt_fwd,
    input  logic [NUM_PORTS-1:0]         pkt_drop,
    input  logic [$clog2(NUM_PORTS)-1:0] cnt_port,
    output logic [egr_tx_pkg::CNT_W-1:0] cnt_fwd,
    output logic [egr_tx_pkg::CNT_W-1:0] cnt_drop
);

    localparam logic [egr_tx_pkg::CNT_W-1:0] CNT_MAX = '1;

    logic [NUM_PORTS-1:0][egr_tx_pkg::CNT_W-1:0] fwd_cnt;
    logic [NUM_PORTS-1:0][egr_tx_pkg::CNT_W-1:0] drop_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Hold at the top value instead of wrapping
                if (pkt_fwd[p] && fwd_cnt[p] != CNT_MAX) begin
                    fwd_cnt[p] <= fwd_cnt[p] + 1'b1;
                end
                if (pkt_drop[p] && drop_cnt[p] != CNT_MAX) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

    // Readout mux
    assign cnt_fwd  = fwd_cnt[cnt_port];
    assign cnt_drop = drop_cnt[cnt_port];

endmodule : tx_pkt_counter

/* tcu.sv */
// ------------------------------------------------
// Transmit controller unit
// Pull scheduler toward the TQU, one port controller
// per EPL port and the per-port packet counters
// ------------------------------------------------

`timescale 1ns/1ps

module tcu #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                         clk,
    input  logic                                         rst,

    // TQU side
    input  logic [NUM_PORTS-1:0]                         dtq_ready,
    input  logic                                         dtq_valid,
    input  logic [egr_tx_pkg::WORD_W-1:0]                dtq_word,
    output logic [NUM_PORTS-1:0]                         dtq_pull,

    // EPL side, one lane per port
    input  logic [NUM_PORTS-1:0]                         epl_ready,
    output logic [NUM_PORTS-1:0]                         tx_valid,
    output logic [NUM_PORTS-1:0][egr_tx_pkg::WORD_W-1:0] tx_data,
    output logic [NUM_PORTS-1:0][egr_tx_pkg::WORD_W/8-1:0] tx_par,
    output logic [NUM_PORTS-1:0]                         tx_sop,
    output logic [NUM_PORTS-1:0]                         tx_eop,

    // Counter readout
    input  logic [$clog2(NUM_PORTS)-1:0]                 cnt_port,
    output logic [egr_tx_pkg::CNT_W-1:0]                 cnt_fwd,
    output logic [egr_tx_pkg::CNT_W-1:0]                 cnt_drop
);

    logic [NUM_PORTS-1:0]          lane_valid;
    logic [egr_tx_pkg::WORD_W-1:0] lane_word;
    logic [NUM_PORTS-1:0]          lane_space;
    logic [NUM_PORTS-1:0]          pkt_fwd;
    logic [NUM_PORTS-1:0]          pkt_drop;

    dtq_pull_sched #(
        .NUM_PORTS (NUM_PORTS)
    ) u_sched (
        .clk        (clk),
        .rst        (rst),
        .dtq_ready  (dtq_ready),
        .dtq_valid  (dtq_valid),
        .dtq_word   (dtq_word),
        .lane_space (lane_space),
        .dtq_pull   (dtq_pull),
        .lane_valid (lane_valid),
        .lane_word  (lane_word)
    );

    // One controller per EPL port, all sharing the lane word
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        tx_port_ctrl u_ctrl (
            .clk        (clk),
            .rst        (rst),
            .lane_valid (lane_valid[p]),
            .lane_word  (lane_word),
            .epl_ready  (epl_ready[p]),
            .lane_space (lane_space[p]),
            .tx_valid   (tx_valid[p]),
            .tx_data    (tx_data[p]),
            .tx_par     (tx_par[p]),
            .tx_sop     (tx_sop[p]),
            .tx_eop     (tx_eop[p]),
            .pkt_fwd    (pkt_fwd[p]),
            .pkt_drop   (pkt_drop[p])
        );
    end

    tx_pkt_counter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_counter (
        .clk      (clk),
        .rst      (rst),
        .pkt_fwd  (pkt_fwd),
        .pkt_drop (pkt_drop),
        .cnt_port (cnt_port),
        .cnt_fwd  (cnt_fwd),
        .cnt_drop (cnt_drop)
    );

endmodule : tcu

/* tcu_checker.sv */
// ------------------------------------------------
// Transmit controller checker
// Concurrent assertions on the TQU pull pulse and
// the EPL hold rules of every port
// ------------------------------------------------

`timescale 1ns/1ps

module tcu_checker #(
    parameter int NUM_PORTS = 4
) (
    input logic                                         clk,
    input logic                                         rst,
    input logic [NUM_PORTS-1:0]                         dtq_pull,
    input logic [NUM_PORTS-1:0]                         epl_ready,
    input logic [NUM_PORTS-1:0]                         tx_valid,
    input logic [NUM_PORTS-1:0]                         lane_valid,
    input logic [NUM_PORTS-1:0][egr_tx_pkg::WORD_W-1:0] tx_data
);

    // Failed assertions so far
    int fail_cnt = 0;

    // At most one queue pulled per cycle
    a_pull_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dtq_pull))
        else begin
            fail_cnt++;
            $error("dtq_pull has more than one bit set");
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // A stalled word stays on the bus unchanged
        a_hold: assert property (@(posedge clk) disable iff (rst)
                tx_valid[p] && !epl_ready[p] |=> tx_valid[p] && $stable(tx_data[p]))
            else begin
                fail_cnt++;
                $error("port %0d changed tx_data while stalled", p);
            end
        // Valid rises only when a lane word has just landed in the buffer
        a_word: assert property (@(posedge clk) disable iff (rst)
                $rose(tx_valid[p]) |-> $past(lane_valid[p]))
            else begin
                fail_cnt++;
                $error("port %0d raised tx_valid without a new lane word", p);
            end
    end

endmodule : tcu_checker

/* tb_tcu.sv */
// ------------------------------------------------
// Transmit controller testbench
// Models the TQU queues and the EPL sinks, plays the
// packet cases and checks each port's word stream
// ------------------------------------------------

`timescale 1ns/1ps

module tb_tcu;

    localparam int NUM_PORTS = 4;
    localparam int IDX_W     = $clog2(NUM_PORTS);
    localparam int WORD_W    = egr_tx_pkg::WORD_W;

    logic                                 clk;
    logic                                 rst;
    logic [NUM_PORTS-1:0]                 dtq_ready;
    logic                                 dtq_valid;
    logic [WORD_W-1:0]                    dtq_word;
    logic [NUM_PORTS-1:0]                 dtq_pull;
    logic [NUM_PORTS-1:0]                 epl_ready;
    logic [NUM_PORTS-1:0]                 tx_valid;
    logic [NUM_PORTS-1:0][WORD_W-1:0]     tx_data;
    logic [NUM_PORTS-1:0][WORD_W/8-1:0]   tx_par;
    logic [NUM_PORTS-1:0]                 tx_sop;
    logic [NUM_PORTS-1:0]                 tx_eop;
    logic [IDX_W-1:0]                     cnt_port;
    logic [egr_tx_pkg::CNT_W-1:0]         cnt_fwd;
    logic [egr_tx_pkg::CNT_W-1:0]         cnt_drop;

    // TQU queues and expected EPL streams per port
    logic [WORD_W-1:0] tqu_q    [NUM_PORTS][$];
    logic [WORD_W-1:0] exp_data [NUM_PORTS][$];
    bit                exp_sop  [NUM_PORTS][$];
    bit                exp_eop  [NUM_PORTS][$];
    int                duty     [NUM_PORTS];
    int                fwd_exp  [NUM_PORTS];
    int                drop_exp [NUM_PORTS];
    int                total_words  = 0;
    int                limit_cycles = 0;
    // Word pulled last cycle and returned this cycle
    bit                pend_valid;
    logic [WORD_W-1:0] pend_word;

    tcu #(
        .NUM_PORTS (NUM_PORTS)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .dtq_ready (dtq_ready),
        .dtq_valid (dtq_valid),
        .dtq_word  (dtq_word),
        .dtq_pull  (dtq_pull),
        .epl_ready (epl_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_par    (tx_par),
        .tx_sop    (tx_sop),
        .tx_eop    (tx_eop),
        .cnt_port  (cnt_port),
        .cnt_fwd   (cnt_fwd),
        .cnt_drop  (cnt_drop)
    );

    bind tcu tcu_checker #(.NUM_PORTS(NUM_PORTS)) u_chk (
        .clk        (clk),
        .rst        (rst),
        .dtq_pull   (dtq_pull),
        .epl_ready  (epl_ready),
        .tx_valid   (tx_valid),
        .lane_valid (lane_valid),
        .tx_data    (tx_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------------------------
    // Reporting
    // ------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Even parity with one bit per byte
    function automatic logic [WORD_W/8-1:0] byte_parity(input logic [WORD_W-1:0] w);
        logic [WORD_W/8-1:0] par;
        int                  ones;
        for (int b = 0; b < WORD_W / 8; b++) begin
            ones = 0;
            for (int i = 0; i < 8; i++) begin
                ones += w[8*b+i];
            end
            par[b] = ones[0];
        end
        return par;
    endfunction

    // ------------------------------------------------
    // Cases file and TQU fill
    // ------------------------------------------------

    task automatic add_packet(input int port, input bit is_drop, input int len, input int pct);
        logic [WORD_W-1:0] w;
        duty[port] = pct;
        // Control word with random upper bits that the DUT ignores
        w = {$urandom, $urandom};
        w[1:0] = is_drop ? egr_tx_pkg::CW_DROP : egr_tx_pkg::CW_FORWARD;
        w[2 +: egr_tx_pkg::LEN_W] = len[egr_tx_pkg::LEN_W-1:0];
        tqu_q[port].push_back(w);
        for (int i = 0; i < len; i++) begin
            w = {$urandom, $urandom};
            tqu_q[port].push_back(w);
            if (!is_drop) begin
                exp_data[port].push_back(w);
                exp_sop[port].push_back(i == 0);
                exp_eop[port].push_back(i == len - 1);
            end
        end
        if (is_drop) drop_exp[port]++;
        else fwd_exp[port]++;
        total_words += len + 1;
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    port;
        int    len;
        int    pct;
        string op_s;
        string line;
        fd = $fopen("tcu_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the cases file tcu_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comment and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %s %d %d", port, op_s, len, pct);
                    if (n != 4 || port < 0 || port >= NUM_PORTS || len < 1 || len > 15 ||
                        (op_s != "FWD" && op_s != "DROP")) begin
                        abort_run({"Malformed line in the cases file: ", line});
                    end else begin
                        add_packet(port, op_s == "DROP", len, pct);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------
    // Per-cycle TQU and EPL models
    // ------------------------------------------------

    task automatic check_word(input int p);
        if (exp_data[p].size() == 0) begin
            abort_run($sformatf("Port %0d sent a word that no case expects", p));
        end else begin
            check_eq(tx_data[p], exp_data[p].pop_front(), $sformatf("port %0d data", p));
            check_eq(tx_sop[p], exp_sop[p].pop_front(), $sformatf("port %0d sop", p));
            check_eq(tx_eop[p], exp_eop[p].pop_front(), $sformatf("port %0d eop", p));
            check_eq(tx_par[p], byte_parity(tx_data[p]), $sformatf("port %0d parity", p));
        end
    endtask

    // Runs on each falling edge
    task automatic service_cycle();
        logic [NUM_PORTS-1:0] rdy;
        dtq_valid  = pend_valid;
        dtq_word   = pend_valid ? pend_word : '0;
        pend_valid = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (dtq_pull[p]) begin
                if (tqu_q[p].size() == 0) begin
                    abort_run($sformatf("Port %0d was pulled with an empty queue", p));
                end else begin
                    pend_word  = tqu_q[p].pop_front();
                    pend_valid = 1'b1;
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            dtq_ready[p] = (tqu_q[p].size() != 0);
            rdy[p]       = ($urandom_range(99) < duty[p]);
        end
        epl_ready = rdy;
        // Outputs settled at the last rising edge and move at the next one
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (tx_valid[p] && rdy[p]) check_word(p);
        end
    endtask

    function automatic bit outstanding();
        bit busy;
        busy = pend_valid || (dtq_pull != '0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            busy |= (tqu_q[p].size() != 0) || (exp_data[p].size() != 0);
        end
        return busy;
    endfunction

    // ------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("Run timed out before all packets drained");
    end

    // Any protocol assertion failure ends the run at once
    initial begin
        wait (UUT.u_chk.fail_cnt != 0);
        abort_run("A protocol assertion failed during the run");
    end

    initial begin
        void'($urandom(32'h91f3));
        rst        = 1'b1;
        dtq_ready  = '0;
        dtq_valid  = 1'b0;
        dtq_word   = '0;
        epl_ready  = '0;
        cnt_port   = '0;
        pend_valid = 1'b0;
        pend_word  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            duty[p]     = 100;
            fwd_exp[p]  = 0;
            drop_exp[p] = 0;
        end
        load_cases();
        limit_cycles = total_words * 40;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Idle after reset with nothing pulled or sent and all counts zero
        for (int p = 0; p < NUM_PORTS; p++) begin
            cnt_port = IDX_W'(p);
            @(negedge clk);
            check_eq(dtq_pull, '0, "dtq_pull while idle");
            check_eq(tx_valid, '0, "tx_valid while idle");
            check_eq(cnt_fwd, '0, $sformatf("idle cnt_fwd port %0d", p));
            check_eq(cnt_drop, '0, $sformatf("idle cnt_drop port %0d", p));
        end

        while (outstanding()) begin
            @(negedge clk);
            service_cycle();
        end
        // Let dropped words and counter pulses settle
        repeat (10) begin
            @(negedge clk);
            service_cycle();
        end

        for (int p = 0; p < NUM_PORTS; p++) begin
            cnt_port = IDX_W'(p);
            @(negedge clk);
            check_eq(cnt_fwd, fwd_exp[p], $sformatf("cnt_fwd port %0d", p));
            check_eq(cnt_drop, drop_exp[p], $sformatf("cnt_drop port %0d", p));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule : tb_tcu

/* tcu_cases.txt */
# port  opcode(FWD|DROP)  length_words(1..15)  epl_ready_duty_percent
# one packet per line, pushed to the port's TQU queue in file order
0 FWD  4  100
1 FWD  1  70
2 FWD  6  10
3 DROP 5  50
0 DROP 3  100
0 FWD  2  100
1 FWD  15 70
3 FWD  8  50
2 DROP 7  10
2 FWD  3  10
1 DROP 1  70
1 FWD  5  70
3 FWD  1  50
0 FWD  12 100
3 DROP 15 50
3 FWD  2  50
2 FWD  9  10
0 FWD  1  100

/* src.f */
egr_tx_pkg.sv
dtq_pull_sched.sv
tx_port_ctrl.sv
tx_pkt_counter.sv
tcu.sv
tcu_checker.sv
tb_tcu.sv

/* Bender.yml */
package:
  name: tcu

sources:
  - egr_tx_pkg.sv
  - dtq_pull_sched.sv
  - tx_port_ctrl.sv
  - tx_pkt_counter.sv
  - tcu.sv
  - target: test
    files:
      - tcu_checker.sv
      - tb_tcu.sv
